//--- include/opnd_defines.svh
//////////////////////////////
// Widths and sizes shared by the operand stage
// Operand width, register address width, register count
//////////////////////////////

`ifndef OPND_DEFINES_SVH
`define OPND_DEFINES_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Operand and ALU result width
`define OPND_WIDTH 32

//////////////////////////////
// Register file
//////////////////////////////

// Bits needed to name one register
`define RF_ADDR_WIDTH 5

// Number of architectural registers
`define RF_WORDS 32

`endif

//--- src/opnd_pkg.sv
//////////////////////////////
// Operand select encodings for A and B
// ALU operation codes
//////////////////////////////

package opnd_pkg;

	// Operand A source
	// Value 2'd1 is unused on A since A never takes the immediate
	typedef enum logic [1:0] {
		SEL_A_RF      = 2'd0,
		SEL_A_EX_FORW = 2'd2,
		SEL_A_WB_FORW = 2'd3
	} sel_a_t;

	// Operand B source
	typedef enum logic [1:0] {
		SEL_B_RF      = 2'd0,
		SEL_B_IMM     = 2'd1,
		SEL_B_EX_FORW = 2'd2,
		SEL_B_WB_FORW = 2'd3
	} sel_b_t;

	// ALU operations
	// SLL shifts A left by the low five bits of B
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5
	} alu_op_t;

endpackage

//--- src/reg_file.sv
//////////////////////////////
// Integer register file
// Two combinational read ports, one write port
//////////////////////////////

`include "opnd_defines.svh"

module reg_file (
	input  logic                      clk,
	input  logic                      arst_n,

	// Read ports
	input  logic [`RF_ADDR_WIDTH-1:0] rd_addr_a,
	input  logic [`RF_ADDR_WIDTH-1:0] rd_addr_b,
	output logic [`OPND_WIDTH-1:0]    rd_data_a,
	output logic [`OPND_WIDTH-1:0]    rd_data_b,

	// Write port from WB
	input  logic                      wr_en,
	input  logic [`RF_ADDR_WIDTH-1:0] wr_addr,
	input  logic [`OPND_WIDTH-1:0]    wr_data
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	// One word per architectural register
	logic [`OPND_WIDTH-1:0] regs [`RF_WORDS];

	// Write strobe with r0 filtered out
	logic                   wr_ok;

	// r0 is hardwired to zero so a write there is dropped
	assign wr_ok = wr_en && (wr_addr != '0);

	// Whole array starts at zero
	// r0 keeps that value forever since it is never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RF_WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Zero latency reads
	// A write in the same cycle is not visible until after the edge
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

//--- src/fwd_ctrl.sv
//////////////////////////////
// Forwarding control for the ID operands
// Source addresses against EX and WB destinations
//////////////////////////////

`include "opnd_defines.svh"

module fwd_ctrl import opnd_pkg::*; (
	// Sources of the instruction in ID
	input  logic [`RF_ADDR_WIDTH-1:0] src_a,
	input  logic [`RF_ADDR_WIDTH-1:0] src_b,
	input  logic                      imm_en,

	// Instruction in EX
	input  logic [`RF_ADDR_WIDTH-1:0] ex_dest,
	input  logic                      ex_valid,

	// Instruction in WB
	input  logic [`RF_ADDR_WIDTH-1:0] wb_dest,
	input  logic                      wb_valid,

	// Operand selects
	output sel_a_t                    sel_a,
	output sel_b_t                    sel_b
);

	// A source hits a stage when that stage holds a real instruction
	// writing the same register
	// r0 never hits because its value is always zero
	function automatic logic src_hit(
		input logic [`RF_ADDR_WIDTH-1:0] src,
		input logic [`RF_ADDR_WIDTH-1:0] dst,
		input logic                      vld
	);
		return vld && (src == dst) && (src != '0);
	endfunction

	// Per source and stage hit flags
	logic ex_hit_a;
	logic wb_hit_a;
	logic ex_hit_b;
	logic wb_hit_b;

	assign ex_hit_a = src_hit(src_a, ex_dest, ex_valid);
	assign wb_hit_a = src_hit(src_a, wb_dest, wb_valid);
	assign ex_hit_b = src_hit(src_b, ex_dest, ex_valid);
	assign wb_hit_b = src_hit(src_b, wb_dest, wb_valid);

	//////////////////////////////
	// Select priority
	//////////////////////////////

	// EX is the younger producer so it wins over WB
	always_comb begin
		if (ex_hit_a) begin
			sel_a = SEL_A_EX_FORW;
		end else if (wb_hit_a) begin
			sel_a = SEL_A_WB_FORW;
		end else begin
			sel_a = SEL_A_RF;
		end
	end

	// Immediate overrides any forward on B
	always_comb begin
		if (imm_en) begin
			sel_b = SEL_B_IMM;
		end else if (ex_hit_b) begin
			sel_b = SEL_B_EX_FORW;
		end else if (wb_hit_b) begin
			sel_b = SEL_B_WB_FORW;
		end else begin
			sel_b = SEL_B_RF;
		end
	end

endmodule

//--- src/operand_muxes.sv
//////////////////////////////
// Operand forwarding multiplexers
// Freeze-aware operand registers with saved flags
//////////////////////////////

`include "opnd_defines.svh"

module operand_muxes import opnd_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,

	// Pipeline freezes
	input  logic                   id_freeze,
	input  logic                   ex_freeze,

	// Candidate operand sources
	input  logic [`OPND_WIDTH-1:0] rf_dataa,
	input  logic [`OPND_WIDTH-1:0] rf_datab,
	input  logic [`OPND_WIDTH-1:0] ex_forw,
	input  logic [`OPND_WIDTH-1:0] wb_forw,
	input  logic [`OPND_WIDTH-1:0] simm,

	// Selects from forwarding control
	input  sel_a_t                 sel_a,
	input  sel_b_t                 sel_b,

	// Registered operands for EX
	output logic [`OPND_WIDTH-1:0] operand_a,
	output logic [`OPND_WIDTH-1:0] operand_b,

	// Combinational mux outputs
	output logic [`OPND_WIDTH-1:0] muxed_a,
	output logic [`OPND_WIDTH-1:0] muxed_b
);

	//////////////////////////////
	// Forwarding muxes
	//////////////////////////////

	// Operand A source
	always_comb begin
		case (sel_a)
			SEL_A_EX_FORW: muxed_a = ex_forw;
			SEL_A_WB_FORW: muxed_a = wb_forw;
			default:       muxed_a = rf_dataa;
		endcase
	end

	// Operand B source
	always_comb begin
		case (sel_b)
			SEL_B_IMM:     muxed_b = simm;
			SEL_B_EX_FORW: muxed_b = ex_forw;
			SEL_B_WB_FORW: muxed_b = wb_forw;
			default:       muxed_b = rf_datab;
		endcase
	end

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Lane 0 carries A, lane 1 carries B
	logic [`OPND_WIDTH-1:0] muxed_v   [2];
	logic [`OPND_WIDTH-1:0] operand_q [2];
	logic                   saved     [2];

	assign muxed_v[0] = muxed_a;
	assign muxed_v[1] = muxed_b;

	// Held while EX is frozen since EX still uses them
	// First load during an ID stall sets saved and locks the value
	// Forward sources may move on while ID waits
	// Saved clears on the release edge without a reload
	for (genvar g = 0; g < 2; g++) begin : g_opnd
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				operand_q[g] <= '0;
				saved[g]     <= 1'b0;
			end else if (!ex_freeze && !saved[g]) begin
				operand_q[g] <= muxed_v[g];
				saved[g]     <= id_freeze;
			end else if (!ex_freeze && !id_freeze) begin
				saved[g]     <= 1'b0;
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

endmodule

//--- src/alu_stage.sv
//////////////////////////////
// EX control register and ALU
// WB result register with bubble insertion
//////////////////////////////

`include "opnd_defines.svh"

module alu_stage import opnd_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,

	// Pipeline freezes
	input  logic                      id_freeze,
	input  logic                      ex_freeze,

	// Instruction fields from ID
	input  alu_op_t                   alu_op,
	input  logic [`RF_ADDR_WIDTH-1:0] dest,

	// Registered operands
	input  logic [`OPND_WIDTH-1:0]    operand_a,
	input  logic [`OPND_WIDTH-1:0]    operand_b,

	// EX stage
	output logic [`OPND_WIDTH-1:0]    ex_forw,
	output logic [`RF_ADDR_WIDTH-1:0] ex_dest,
	output logic                      ex_valid,

	// WB stage
	output logic [`OPND_WIDTH-1:0]    wb_forw,
	output logic [`RF_ADDR_WIDTH-1:0] wb_dest,
	output logic                      wb_valid
);

	// Shift amount bits taken from B
	localparam int SHAMT_W = $clog2(`OPND_WIDTH);

	alu_op_t ex_op;

	//////////////////////////////
	// EX register
	//////////////////////////////

	// Holds while EX is frozen
	// An ID-only freeze lets a bubble in
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_op    <= ALU_ADD;
			ex_dest  <= '0;
			ex_valid <= 1'b0;
		end else if (!ex_freeze) begin
			ex_op    <= alu_op;
			ex_dest  <= dest;
			ex_valid <= !id_freeze;
		end
	end

	// ALU, also the EX forward
	always_comb begin
		case (ex_op)
			ALU_ADD: ex_forw = operand_a + operand_b;
			ALU_SUB: ex_forw = operand_a - operand_b;
			ALU_AND: ex_forw = operand_a & operand_b;
			ALU_OR:  ex_forw = operand_a | operand_b;
			ALU_XOR: ex_forw = operand_a ^ operand_b;
			ALU_SLL: ex_forw = operand_a << operand_b[SHAMT_W-1:0];
			default: ex_forw = '0;
		endcase
	end

	//////////////////////////////
	// WB register
	//////////////////////////////

	// EX frozen means nothing leaves EX, so WB gets a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_forw  <= '0;
			wb_dest  <= '0;
			wb_valid <= 1'b0;
		end else if (!ex_freeze) begin
			wb_forw  <= ex_forw;
			wb_dest  <= ex_dest;
			wb_valid <= ex_valid;
		end else begin
			wb_valid <= 1'b0;
		end
	end

endmodule

//--- src/exec_front_top.sv
//////////////////////////////
// Operand stage top level
// Register file, forwarding, operand muxes, ALU stage
//////////////////////////////

`include "opnd_defines.svh"

module exec_front_top import opnd_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,

	// Freezes from outside the pipeline
	input  logic                      id_freeze,
	input  logic                      ex_freeze,

	// Instruction in ID
	input  logic [`RF_ADDR_WIDTH-1:0] src_a,
	input  logic [`RF_ADDR_WIDTH-1:0] src_b,
	input  logic                      imm_en,
	input  logic [`OPND_WIDTH-1:0]    simm,
	input  alu_op_t                   alu_op,
	input  logic [`RF_ADDR_WIDTH-1:0] dest,

	// Writeback
	output logic [`OPND_WIDTH-1:0]    result,
	output logic [`RF_ADDR_WIDTH-1:0] wb_dest,
	output logic                      wb_valid
);

	// Register file reads
	logic [`OPND_WIDTH-1:0]    rf_dataa;
	logic [`OPND_WIDTH-1:0]    rf_datab;

	// Selects
	sel_a_t                    sel_a;
	sel_b_t                    sel_b;

	// EX side
	logic [`OPND_WIDTH-1:0]    operand_a;
	logic [`OPND_WIDTH-1:0]    operand_b;
	logic [`OPND_WIDTH-1:0]    ex_forw;
	logic [`RF_ADDR_WIDTH-1:0] ex_dest;
	logic                      ex_valid;

	// WB result is written back here
	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (src_a),
		.rd_addr_b (src_b),
		.rd_data_a (rf_dataa),
		.rd_data_b (rf_datab),
		.wr_en     (wb_valid),
		.wr_addr   (wb_dest),
		.wr_data   (result)
	);

	fwd_ctrl u_fwd_ctrl (
		.src_a    (src_a),
		.src_b    (src_b),
		.imm_en   (imm_en),
		.ex_dest  (ex_dest),
		.ex_valid (ex_valid),
		.wb_dest  (wb_dest),
		.wb_valid (wb_valid),
		.sel_a    (sel_a),
		.sel_b    (sel_b)
	);

	// Mux outputs are only observed inside the block
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (result),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.muxed_a   (),
		.muxed_b   ()
	);

	alu_stage u_alu_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.alu_op    (alu_op),
		.dest      (dest),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_forw   (ex_forw),
		.ex_dest   (ex_dest),
		.ex_valid  (ex_valid),
		.wb_forw   (result),
		.wb_dest   (wb_dest),
		.wb_valid  (wb_valid)
	);

endmodule

//--- sim/exec_front_sva.sv
//////////////////////////////
// Assertions on the operand stage top level
// Freeze bubbles, writeback latency, reset state
//////////////////////////////

`include "opnd_defines.svh"

module exec_front_sva (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   id_freeze,
	input logic                   ex_freeze,
	input logic [`OPND_WIDTH-1:0] result,
	input logic                   wb_valid
);

	// Failure count
	int assert_fails = 0;

	// Frozen EX hands a bubble to WB
	a_freeze_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		ex_freeze |=> !wb_valid)
	else begin
		assert_fails++;
		$error("wb_valid high in the cycle after an EX freeze");
	end

	// Written back data must be fully known
	a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> !$isunknown(result))
	else begin
		assert_fails++;
		$error("result has unknown bits while wb_valid is high");
	end

	// Accepted with no freeze, written back two edges later
	a_wb_latency: assert property (@(posedge clk) disable iff (!arst_n)
		(!id_freeze && !ex_freeze) ##1 !ex_freeze |=> wb_valid)
	else begin
		assert_fails++;
		$error("accepted instruction missing on WB two edges later");
	end

	// First edge out of reset
	a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !wb_valid)
	else begin
		assert_fails++;
		$error("wb_valid high right after reset");
	end

endmodule

//--- sim/exec_front_tb.sv
//////////////////////////////
// Testbench for the operand stage top level
// Directed and random instruction streams with freezes
// Reference model, scoreboard, timeout
//////////////////////////////

`include "opnd_defines.svh"

module exec_front_tb import opnd_pkg::*; ();

	// Tests need about 650 cycles, so this is roughly three times that
	localparam int MAX_CYCLES = 2000;

	logic                      clk;
	logic                      arst_n;
	logic                      id_freeze;
	logic                      ex_freeze;
	logic [`RF_ADDR_WIDTH-1:0] src_a;
	logic [`RF_ADDR_WIDTH-1:0] src_b;
	logic                      imm_en;
	logic [`OPND_WIDTH-1:0]    simm;
	alu_op_t                   alu_op;
	logic [`RF_ADDR_WIDTH-1:0] dest;
	logic [`OPND_WIDTH-1:0]    result;
	logic [`RF_ADDR_WIDTH-1:0] wb_dest;
	logic                      wb_valid;

	// Architectural registers and expected writebacks in program order
	logic [`OPND_WIDTH-1:0]    arch_regs [`RF_WORDS];
	logic [`OPND_WIDTH-1:0]    exp_result_q [$];
	logic [`RF_ADDR_WIDTH-1:0] exp_dest_q [$];

	int seed = 56;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int checked_cnt = 0;
	int test_num = 0;
	int test_chk_base = 0;
	int test_err_base = 0;
	int sva_fails;

	exec_front_top u_exec_front_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.src_a     (src_a),
		.src_b     (src_b),
		.imm_en    (imm_en),
		.simm      (simm),
		.alu_op    (alu_op),
		.dest      (dest),
		.result    (result),
		.wb_dest   (wb_dest),
		.wb_valid  (wb_valid)
	);

	bind exec_front_top exec_front_sva u_exec_front_sva (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.result    (result),
		.wb_valid  (wb_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Executes one instruction on the architectural state
	// r0 stays zero, the result still goes out on WB
	function automatic logic [`OPND_WIDTH-1:0] ref_exec(
		input logic [`RF_ADDR_WIDTH-1:0] sa,
		input logic [`RF_ADDR_WIDTH-1:0] sb,
		input logic                      use_imm,
		input logic [`OPND_WIDTH-1:0]    imm,
		input alu_op_t                   op,
		input logic [`RF_ADDR_WIDTH-1:0] dst
	);
		logic [`OPND_WIDTH-1:0] a;
		logic [`OPND_WIDTH-1:0] b;
		logic [`OPND_WIDTH-1:0] res;
		a = arch_regs[sa];
		b = use_imm ? imm : arch_regs[sb];
		case (op)
			ALU_ADD: res = a + b;
			ALU_SUB: res = a - b;
			ALU_AND: res = a & b;
			ALU_OR:  res = a | b;
			ALU_XOR: res = a ^ b;
			ALU_SLL: res = a << b[4:0];
			default: res = '0;
		endcase
		if (dst != 0) begin
			arch_regs[dst] = res;
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [`OPND_WIDTH-1:0] expected,
		input logic [`OPND_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			err_cnt++;
		end
	endtask

	// Compare the writeback first, then record what this edge accepts
	always @(posedge clk) begin : scoreboard
		logic [`OPND_WIDTH-1:0]    exp_res;
		logic [`RF_ADDR_WIDTH-1:0] exp_dst;
		if (arst_n) begin
			if (wb_valid) begin
				if (exp_result_q.size() == 0) begin
					$display("ERROR at %0t: writeback with no instruction pending", $time);
					err_cnt++;
				end else begin
					exp_res = exp_result_q.pop_front();
					exp_dst = exp_dest_q.pop_front();
					check_value("result", exp_res, result);
					check_value("wb_dest", exp_dst, wb_dest);
					checked_cnt++;
				end
			end
			// No freeze on ID means the instruction on the ports is taken
			if (!id_freeze) begin
				exp_result_q.push_back(ref_exec(src_a, src_b, imm_en, simm, alu_op, dest));
				exp_dest_q.push_back(dest);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("ERROR: run stopped after %0d cycles without finishing", cycle_cnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Holds the instruction under stalls, then lets ID take it
	// ex_stall allows EX freezes inside the stall, never outside it
	task automatic issue_instr(
		input logic [`RF_ADDR_WIDTH-1:0] sa,
		input logic [`RF_ADDR_WIDTH-1:0] sb,
		input logic                      use_imm,
		input logic [`OPND_WIDTH-1:0]    imm,
		input alu_op_t                   op,
		input logic [`RF_ADDR_WIDTH-1:0] dst,
		input int                        stalls,
		input logic                      ex_stall
	);
		int r;
		// A NOP parked in ID while idle goes in first
		if (id_freeze) begin
			id_freeze <= 1'b0;
			ex_freeze <= 1'b0;
			@(posedge clk);
		end
		src_a  <= sa;
		src_b  <= sb;
		imm_en <= use_imm;
		simm   <= imm;
		alu_op <= op;
		dest   <= dst;
		for (int i = 0; i < stalls; i++) begin
			r = $random(seed);
			id_freeze <= 1'b1;
			ex_freeze <= ex_stall && r[0];
			@(posedge clk);
		end
		id_freeze <= 1'b0;
		ex_freeze <= 1'b0;
		@(posedge clk);
	endtask

	// dep_pct picks sources among the last three destinations
	task automatic random_run(input int count, input int dep_pct, input int stall_pct);
		logic [`RF_ADDR_WIDTH-1:0] recent [3];
		logic [`RF_ADDR_WIDTH-1:0] sa;
		logic [`RF_ADDR_WIDTH-1:0] sb;
		logic [`RF_ADDR_WIDTH-1:0] dst;
		logic [`OPND_WIDTH-1:0]    imm_raw;
		logic                      use_imm;
		logic                      ex_stall;
		alu_op_t                   op;
		int                        stalls;
		for (int i = 0; i < 3; i++) begin
			recent[i] = `RF_ADDR_WIDTH'(rand_below(`RF_WORDS));
		end
		for (int n = 0; n < count; n++) begin
			sa = (rand_below(100) < dep_pct) ? recent[rand_below(3)]
				: `RF_ADDR_WIDTH'(rand_below(`RF_WORDS));
			sb = (rand_below(100) < dep_pct) ? recent[rand_below(3)]
				: `RF_ADDR_WIDTH'(rand_below(`RF_WORDS));
			dst = `RF_ADDR_WIDTH'(rand_below(`RF_WORDS));
			imm_raw = $random(seed);
			use_imm = (rand_below(4) == 0);
			op = alu_op_t'(rand_below(6));
			stalls = (rand_below(100) < stall_pct) ? 1 + rand_below(3) : 0;
			ex_stall = (rand_below(2) != 0);
			// Immediate is a sign-extended 12 bit field
			issue_instr(sa, sb, use_imm, {{(`OPND_WIDTH-12){imm_raw[11]}}, imm_raw[11:0]},
				op, dst, stalls, ex_stall);
			recent[2] = recent[1];
			recent[1] = recent[0];
			recent[0] = dst;
		end
	endtask

	// Drain the pipeline and report the test
	// ID holds a NOP meanwhile, taken later by the next instruction issue
	task automatic finish_test(input string name);
		src_a     <= '0;
		src_b     <= '0;
		imm_en    <= 1'b0;
		simm      <= '0;
		alu_op    <= ALU_ADD;
		dest      <= '0;
		id_freeze <= 1'b1;
		ex_freeze <= 1'b0;
		do begin
			@(negedge clk);
		end while (exp_result_q.size() != 0);
		@(posedge clk);
		test_num++;
		$display("Test %0d (%s) done: %0d results checked, %0d errors", test_num, name,
			checked_cnt - test_chk_base, err_cnt - test_err_base);
		test_chk_base = checked_cnt;
		test_err_base = err_cnt;
	endtask

	initial begin
		for (int i = 0; i < `RF_WORDS; i++) begin
			arch_regs[i] = '0;
		end
		arst_n    <= 1'b0;
		id_freeze <= 1'b1;
		ex_freeze <= 1'b0;
		src_a     <= '0;
		src_b     <= '0;
		imm_en    <= 1'b0;
		simm      <= '0;
		alu_op    <= ALU_ADD;
		dest      <= '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		// Loads from r0 plus immediate, then every op through the register file
		issue_instr(0, 0, 1, 32'h0000_1234, ALU_ADD, 1, 0, 0);
		issue_instr(0, 0, 1, 32'hffff_f00f, ALU_ADD, 2, 0, 0);
		issue_instr(0, 0, 1, 32'h0f0f_0f0f, ALU_ADD, 3, 0, 0);
		issue_instr(0, 0, 1, 32'h0000_0007, ALU_ADD, 4, 0, 0);
		issue_instr(0, 0, 1, 32'h8000_0001, ALU_ADD, 5, 0, 0);
		issue_instr(0, 0, 1, 32'h0000_0013, ALU_ADD, 6, 0, 0);
		issue_instr(1, 2, 0, 0, ALU_ADD, 7, 0, 0);
		issue_instr(3, 4, 0, 0, ALU_SUB, 8, 0, 0);
		issue_instr(5, 6, 0, 0, ALU_AND, 9, 0, 0);
		issue_instr(1, 6, 0, 0, ALU_OR, 10, 0, 0);
		issue_instr(2, 5, 0, 0, ALU_XOR, 11, 0, 0);
		issue_instr(3, 4, 0, 0, ALU_SLL, 12, 0, 0);
		finish_test("independent ops");

		// Back to back, forwarded from EX on A, on B, and on both
		issue_instr(0, 0, 1, 32'h0000_0011, ALU_ADD, 13, 0, 0);
		issue_instr(13, 0, 1, 32'h0000_0022, ALU_ADD, 14, 0, 0);
		issue_instr(1, 14, 0, 0, ALU_SUB, 15, 0, 0);
		issue_instr(15, 15, 0, 0, ALU_XOR, 16, 0, 0);
		issue_instr(16, 2, 0, 0, ALU_OR, 17, 0, 0);
		issue_instr(3, 17, 0, 0, ALU_SLL, 18, 0, 0);
		finish_test("EX forwarding");

		// Distance two from WB, distance three from the register file
		issue_instr(0, 0, 1, 32'h0000_0100, ALU_ADD, 20, 0, 0);
		issue_instr(0, 0, 1, 32'h0000_00f0, ALU_ADD, 21, 0, 0);
		issue_instr(20, 3, 0, 0, ALU_AND, 22, 0, 0);
		issue_instr(4, 21, 0, 0, ALU_OR, 23, 0, 0);
		issue_instr(21, 22, 0, 0, ALU_ADD, 24, 0, 0);
		issue_instr(24, 23, 0, 0, ALU_XOR, 25, 0, 0);
		issue_instr(25, 0, 1, 32'h0000_0001, ALU_ADD, 25, 0, 0);
		// r25 sits in both EX and WB here, the younger copy must win
		issue_instr(25, 24, 0, 0, ALU_ADD, 26, 0, 0);
		finish_test("WB forwarding and register file");

		// Immediate beats a B forward hit, r0 writes vanish
		issue_instr(0, 0, 1, 32'h0000_0055, ALU_ADD, 28, 0, 0);
		issue_instr(28, 28, 1, 32'h0000_0003, ALU_ADD, 29, 0, 0);
		issue_instr(29, 29, 1, 32'h0000_0077, ALU_ADD, 0, 0, 0);
		issue_instr(0, 0, 0, 0, ALU_ADD, 30, 0, 0);
		issue_instr(0, 29, 0, 0, ALU_OR, 31, 0, 0);
		issue_instr(0, 0, 0, 0, ALU_XOR, 27, 0, 0);
		finish_test("immediate and r0");

		random_run(40, 100, 60);
		finish_test("stalls on dependent chains");

		random_run(300, 50, 25);
		finish_test("random mix");

		sva_fails = u_exec_front_top.u_exec_front_sva.assert_fails;
		if (exp_result_q.size() != 0) begin
			$display("ERROR: %0d instructions never wrote back", exp_result_q.size());
			err_cnt++;
		end
		$display("Summary: %0d tests, %0d results checked, %0d check errors, %0d assertion failures",
			test_num, checked_cnt, err_cnt, sva_fails);
		if (err_cnt == 0 && sva_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
src/opnd_pkg.sv
src/reg_file.sv
src/fwd_ctrl.sv
src/operand_muxes.sv
src/alu_stage.sv
src/exec_front_top.sv
sim/exec_front_sva.sv
sim/exec_front_tb.sv

//--- Bender.yml
package:
  name: exec_front

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/opnd_pkg.sv
      - src/reg_file.sv
      - src/fwd_ctrl.sv
      - src/operand_muxes.sv
      - src/alu_stage.sv
      - src/exec_front_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/exec_front_sva.sv
      - sim/exec_front_tb.sv
